//--- frame_gen.sv
// #####################################
// Test frame generator
// Preamble, SFD, incrementing payload
// #####################################
`timescale 1ns/1ps

module frame_gen (
	input  logic                         tx_clk,
	input  logic                         arst_n,
	input  rgmii_hw_test_pkg::test_cfg_t cfg,
	input  logic                         send,
	output rgmii_hw_test_pkg::gmii_t     tx
);
	import rgmii_hw_test_pkg::*;

	// Inter-frame gap in byte times
	localparam logic [3:0] IFG_CYCLES = 4'd12;

	gen_state_e       state;
	logic [3:0]       byte_cnt;
	logic [3:0]       gap_cnt;
	logic [LEN_W-1:0] rem_cnt;
	logic [7:0]       data_q;
	logic             start;
	logic             emit;

	assign start = (state == GEN_IDLE) && (gap_cnt == '0) && send;
	assign emit = ((state == GEN_SFD) || (state == GEN_DATA)) && (rem_cnt != '0);

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= GEN_IDLE;
			byte_cnt <= '0;
			gap_cnt <= '0;
			tx <= '0;
		end else begin
			case (state)
				GEN_IDLE: begin
					if (gap_cnt != '0) begin
						gap_cnt <= gap_cnt - 4'd1;
					end else if (start) begin
						tx.en <= 1'b1;
						tx.data <= PREAMBLE_BYTE;
						byte_cnt <= 4'd1;
						state <= GEN_PRE;
					end
				end
				GEN_PRE: begin
					if (byte_cnt == PREAMBLE_LEN) begin
						tx.data <= SFD_BYTE;
						state <= GEN_SFD;
					end else begin
						tx.data <= PREAMBLE_BYTE;
						byte_cnt <= byte_cnt + 4'd1;
					end
				end
				GEN_SFD, GEN_DATA: begin
					if (emit) begin
						tx.data <= data_q;
						state <= GEN_DATA;
					end else begin
						// Last byte is out, start the gap
						tx.en <= 1'b0;
						tx.data <= '0;
						gap_cnt <= IFG_CYCLES;
						state <= GEN_IDLE;
					end
				end
				default: state <= GEN_IDLE;
			endcase
		end
	end

	// Length and seed latched at start, then walked byte by byte
	always_ff @(posedge tx_clk) begin
		if (start) begin
			rem_cnt <= cfg.len;
			data_q <= cfg.seed;
		end else if (emit) begin
			rem_cnt <= rem_cnt - 1'b1;
			data_q <= data_q + 8'd1;
		end
	end

endmodule

//--- frame_rx.sv
// #####################################
// Received frame checker
// Verifies payload and counts good frames
// #####################################
`timescale 1ns/1ps

module frame_rx (
	input  logic                        tx_clk,
	input  logic                        arst_n,
	input  rgmii_hw_test_pkg::gmii_t    rx,
	input  logic                        clear,
	output rgmii_hw_test_pkg::rx_stat_t stat
);
	import rgmii_hw_test_pkg::*;

	rx_state_e  state;
	logic [7:0] exp_byte;
	logic       frame_err;
	logic       got_payload;
	logic       frame_end;
	logic       frame_good;

	// First idle byte after any frame activity
	assign frame_end = (state != RX_IDLE) && !rx.en;
	assign frame_good = got_payload && !frame_err;

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= RX_IDLE;
			frame_err <= 1'b0;
			got_payload <= 1'b0;
		end else begin
			case (state)
				RX_IDLE: begin
					if (rx.en) begin
						frame_err <= rx.er;
						got_payload <= 1'b0;
						state <= (rx.data == SFD_BYTE) ? RX_FIRST : RX_PRE;
					end
				end
				RX_PRE: begin
					// Skip preamble, whatever its length
					if (!rx.en) begin
						state <= RX_IDLE;
					end else begin
						frame_err <= frame_err | rx.er;
						if (rx.data == SFD_BYTE) begin
							state <= RX_FIRST;
						end
					end
				end
				RX_FIRST: begin
					if (!rx.en) begin
						state <= RX_IDLE;
					end else begin
						frame_err <= frame_err | rx.er;
						got_payload <= 1'b1;
						state <= RX_DATA;
					end
				end
				RX_DATA: begin
					if (!rx.en) begin
						state <= RX_IDLE;
					end else begin
						frame_err <= frame_err | rx.er | (rx.data != exp_byte);
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Next byte must be this one plus one, wrapping
	always_ff @(posedge tx_clk) begin
		if (rx.en && ((state == RX_FIRST) || (state == RX_DATA))) begin
			exp_byte <= rx.data + 8'd1;
		end
	end

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			stat <= '0;
		end else if (clear) begin
			stat <= '0;
		end else if (frame_end) begin
			if (frame_good) begin
				stat.good_count <= stat.good_count + 8'd1;
			end else begin
				stat.bad_seen <= 1'b1;
			end
		end
	end

endmodule

//--- gmii_to_rgmii.sv
// #####################################
// GMII to RGMII DDR converter
// Byte lanes to nibbles on both clock edges
// #####################################
`timescale 1ns/1ps

module gmii_to_rgmii (
	input  logic                     tx_clk,
	input  logic                     arst_n,
	input  rgmii_hw_test_pkg::gmii_t gmii_tx,
	input  logic [3:0]               rgmii_rxd,
	input  logic                     rgmii_rx_ctl,
	output logic [3:0]               rgmii_txd,
	output logic                     rgmii_tx_ctl,
	output logic                     rgmii_tx_clk,
	output rgmii_hw_test_pkg::gmii_t gmii_rx
);
	import rgmii_hw_test_pkg::*;

	gmii_t tx_q;

	// Rising edge half of the RX byte
	logic [3:0] rx_lo;
	logic       rx_dv;

	// Falling edge half of the RX byte
	logic [3:0] rx_hi;
	logic       rx_ctl_fall;

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_q <= '0;
		end else begin
			tx_q <= gmii_tx;
		end
	end

	// Low nibble in the high phase, high nibble in the low phase
	assign rgmii_txd = tx_clk ? tx_q.data[3:0] : tx_q.data[7:4];
	assign rgmii_tx_ctl = tx_clk ? tx_q.en : (tx_q.en ^ tx_q.er);

	// Forwarded clock, edges centered on nothing in particular
	assign rgmii_tx_clk = tx_clk;

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_lo <= '0;
			rx_dv <= 1'b0;
		end else begin
			rx_lo <= rgmii_rxd;
			rx_dv <= rgmii_rx_ctl;
		end
	end

	always_ff @(negedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_hi <= '0;
			rx_ctl_fall <= 1'b0;
		end else begin
			rx_hi <= rgmii_rxd;
			rx_ctl_fall <= rgmii_rx_ctl;
		end
	end

	// Rejoin both halves on the next rising edge
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			gmii_rx <= '0;
		end else begin
			gmii_rx.data <= {rx_hi, rx_lo};
			gmii_rx.en <= rx_dv;
			gmii_rx.er <= rx_dv ^ rx_ctl_fall;
		end
	end

endmodule

//--- hw_test.sv
// #####################################
// Ethernet link test engine
// Config, generator, checker, PHY reset, LEDs
// #####################################
`timescale 1ns/1ps

module hw_test #(
	parameter int PHY_RST_CYCLES = 1000
) (
	input  logic                     tx_clk,
	input  logic                     arst_n,
	input  rgmii_hw_test_pkg::gmii_t gmii_rx,
	input  logic                     sclk,
	input  logic                     csb,
	input  logic                     mosi,
	output rgmii_hw_test_pkg::gmii_t gmii_tx,
	output logic                     phy_rstn,
	output logic [3:0]               led
);
	import rgmii_hw_test_pkg::*;

	localparam int RST_CNT_W = $clog2(PHY_RST_CYCLES + 1);

	test_cfg_t              cfg;
	test_cmd_t              cmd;
	rx_stat_t               stat;
	logic [RST_CNT_W-1:0]   rst_cnt;
	logic                   rst_done;

	spi_config spi_config_inst (
		.tx_clk (tx_clk),
		.arst_n (arst_n),
		.sclk   (sclk),
		.csb    (csb),
		.mosi   (mosi),
		.cfg    (cfg),
		.cmd    (cmd)
	);

	frame_gen frame_gen_inst (
		.tx_clk (tx_clk),
		.arst_n (arst_n),
		.cfg    (cfg),
		.send   (cmd.send),
		.tx     (gmii_tx)
	);

	frame_rx frame_rx_inst (
		.tx_clk (tx_clk),
		.arst_n (arst_n),
		.rx     (gmii_rx),
		.clear  (cmd.clear),
		.stat   (stat)
	);

	// Hold the PHY in reset for a fixed time after our own reset
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			rst_cnt <= '0;
			rst_done <= 1'b0;
		end else if (!rst_done) begin
			if (rst_cnt == RST_CNT_W'(PHY_RST_CYCLES - 1)) begin
				rst_done <= 1'b1;
			end else begin
				rst_cnt <= rst_cnt + 1'b1;
			end
		end
	end

	// Software can also force it
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			phy_rstn <= 1'b0;
		end else begin
			phy_rstn <= rst_done && !cfg.phy_force_rst;
		end
	end

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			led <= '0;
		end else begin
			led <= {stat.bad_seen, stat.good_count[2:0]};
		end
	end

endmodule

//--- rgmii_hw_test.f
rgmii_hw_test_pkg.sv
gmii_to_rgmii.sv
spi_config.sv
frame_gen.sv
frame_rx.sv
hw_test.sv
rgmii_hw_test.sv
tb_rgmii_hw_test.sv

//--- rgmii_hw_test.sv
// #####################################
// RGMII hardware test, board top
// DDR converter plus the test engine
// #####################################
`timescale 1ns/1ps

module rgmii_hw_test #(
	parameter int PHY_RST_CYCLES = 1000
) (
	input  logic       tx_clk,
	input  logic       arst_n,

	// RGMII receive pins
	input  logic [3:0] rgmii_rxd,
	input  logic       rgmii_rx_ctl,

	// SPI configuration pins
	input  logic       sclk,
	input  logic       csb,
	input  logic       mosi,

	// RGMII transmit pins
	output logic [3:0] rgmii_txd,
	output logic       rgmii_tx_ctl,
	output logic       rgmii_tx_clk,

	output logic       phy_rstn,
	output logic [3:0] led
);
	import rgmii_hw_test_pkg::*;

	gmii_t gmii_tx;
	gmii_t gmii_rx;

	gmii_to_rgmii gmii_to_rgmii_inst (
		.tx_clk       (tx_clk),
		.arst_n       (arst_n),
		.gmii_tx      (gmii_tx),
		.rgmii_rxd    (rgmii_rxd),
		.rgmii_rx_ctl (rgmii_rx_ctl),
		.rgmii_txd    (rgmii_txd),
		.rgmii_tx_ctl (rgmii_tx_ctl),
		.rgmii_tx_clk (rgmii_tx_clk),
		.gmii_rx      (gmii_rx)
	);

	hw_test #(
		.PHY_RST_CYCLES (PHY_RST_CYCLES)
	) hw_test_inst (
		.tx_clk   (tx_clk),
		.arst_n   (arst_n),
		.gmii_rx  (gmii_rx),
		.sclk     (sclk),
		.csb      (csb),
		.mosi     (mosi),
		.gmii_tx  (gmii_tx),
		.phy_rstn (phy_rstn),
		.led      (led)
	);

endmodule

//--- rgmii_hw_test_pkg.sv
// #####################################
// RGMII link tester shared definitions
// Constants, state enums and bus structs
// #####################################
package rgmii_hw_test_pkg;

	// Payload length field width
	localparam int LEN_W = 12;

	// Ethernet framing bytes
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hd5;
	localparam logic [3:0] PREAMBLE_LEN = 4'd7;

	// SPI register map, top nibble of each word
	typedef enum logic [3:0] {
		ADDR_LEN  = 4'd0,
		ADDR_SEED = 4'd1,
		ADDR_CMD  = 4'd2
	} cfg_addr_e;

	typedef enum logic [1:0] {
		GEN_IDLE,
		GEN_PRE,
		GEN_SFD,
		GEN_DATA
	} gen_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_PRE,
		RX_FIRST,
		RX_DATA
	} rx_state_e;

	// One GMII byte lane, en is tx_en or rx_dv
	typedef struct packed {
		logic [7:0] data;
		logic       en;
		logic       er;
	} gmii_t;

	typedef struct packed {
		logic [LEN_W-1:0] len;
		logic [7:0]       seed;
		logic             phy_force_rst;
	} test_cfg_t;

	// Single-cycle command strobes
	typedef struct packed {
		logic send;
		logic clear;
	} test_cmd_t;

	typedef struct packed {
		logic [7:0] good_count;
		logic       bad_seen;
	} rx_stat_t;

endpackage

//--- spi_config.sv
// #####################################
// SPI write-only configuration port
// 16-bit words into registers and strobes
// #####################################
`timescale 1ns/1ps

module spi_config (
	input  logic                         tx_clk,
	input  logic                         arst_n,
	input  logic                         sclk,
	input  logic                         csb,
	input  logic                         mosi,
	output rgmii_hw_test_pkg::test_cfg_t cfg,
	output rgmii_hw_test_pkg::test_cmd_t cmd
);
	import rgmii_hw_test_pkg::*;

	localparam int WORD_BITS = 16;
	localparam logic [LEN_W-1:0] LEN_RESET = LEN_W'(64);

	logic [1:0]           sclk_sync;
	logic [1:0]           csb_sync;
	logic [1:0]           mosi_sync;
	logic                 sclk_q;
	logic                 csb_q;
	logic                 sclk_rise;
	logic                 csb_rise;
	logic [WORD_BITS-1:0] shift_reg;
	logic [4:0]           bit_cnt;
	cfg_addr_e            word_addr;
	logic [LEN_W-1:0]     word_data;

	// Two-flop synchronizers, csb idles high
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			sclk_sync <= '0;
			csb_sync <= '1;
			mosi_sync <= '0;
			sclk_q <= 1'b0;
			csb_q <= 1'b1;
		end else begin
			sclk_sync <= {sclk_sync[0], sclk};
			csb_sync <= {csb_sync[0], csb};
			mosi_sync <= {mosi_sync[0], mosi};
			sclk_q <= sclk_sync[1];
			csb_q <= csb_sync[1];
		end
	end

	assign sclk_rise = sclk_sync[1] & ~sclk_q;
	assign csb_rise = csb_sync[1] & ~csb_q;

	// MSB first, mosi has the same sync depth as sclk
	always_ff @(posedge tx_clk) begin
		if (!csb_sync[1] && sclk_rise) begin
			shift_reg <= {shift_reg[WORD_BITS-2:0], mosi_sync[1]};
		end
	end

	// Saturates so long transfers never alias to 16
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt <= '0;
		end else if (csb_sync[1]) begin
			bit_cnt <= '0;
		end else if (sclk_rise && bit_cnt != '1) begin
			bit_cnt <= bit_cnt + 5'd1;
		end
	end

	assign word_addr = cfg_addr_e'(shift_reg[WORD_BITS-1:LEN_W]);
	assign word_data = shift_reg[LEN_W-1:0];

	// Commit on csb rising, only for a full word
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg.len <= LEN_RESET;
			cfg.seed <= '0;
			cfg.phy_force_rst <= 1'b0;
			cmd <= '0;
		end else begin
			cmd <= '0;
			if (csb_rise && bit_cnt == 5'(WORD_BITS)) begin
				case (word_addr)
					ADDR_LEN: cfg.len <= word_data;
					ADDR_SEED: cfg.seed <= word_data[7:0];
					ADDR_CMD: begin
						cmd.send <= word_data[0];
						cmd.clear <= word_data[1];
						cfg.phy_force_rst <= word_data[2];
					end
					default: ;
				endcase
			end
		end
	end

endmodule

//--- tb_rgmii_hw_test.sv
// ########################################
// RGMII link tester testbench
// Table-driven frames, TX decode, RX loopback or injection
// ########################################
`timescale 1ns/1ps

module tb_rgmii_hw_test;
	import rgmii_hw_test_pkg::*;

	typedef enum logic [1:0] {CORR_NONE, CORR_BYTE, CORR_ER, CORR_NO_SFD} corr_kind_e;

	typedef struct packed {
		logic [LEN_W-1:0] len;
		logic [7:0]       seed;
		logic             inject;
		corr_kind_e       kind;
		logic             clear_first;
		logic [3:0]       exp_led;
	} test_row_t;

	localparam int NUM_ROWS = 13;

	logic        tx_clk;
	logic        arst_n;
	logic        sclk;
	logic        csb;
	logic        mosi;
	logic [3:0]  rgmii_rxd;
	logic        rgmii_rx_ctl;
	logic [3:0]  rgmii_txd;
	logic        rgmii_tx_ctl;
	logic        rgmii_tx_clk;
	logic        phy_rstn;
	logic [3:0]  led;

	test_row_t   rows [NUM_ROWS];
	gmii_t       rx_byte;
	gmii_t       inj_byte;
	gmii_t       dec_byte;
	logic        loopback;
	logic        in_frame;
	logic        tx_er_seen;
	logic [3:0]  dec_lo;
	logic        dec_ctl;
	logic [7:0]  cap_q[$];
	logic [7:0]  last_frame[$];
	int          frames_seen;
	int          test_err;
	int          pass_cnt;
	int          fail_cnt;
	int unsigned seed_val;

	rgmii_hw_test #(
		.PHY_RST_CYCLES (16)
	) rgmii_hw_test_inst (
		.tx_clk       (tx_clk),
		.arst_n       (arst_n),
		.rgmii_rxd    (rgmii_rxd),
		.rgmii_rx_ctl (rgmii_rx_ctl),
		.sclk         (sclk),
		.csb          (csb),
		.mosi         (mosi),
		.rgmii_txd    (rgmii_txd),
		.rgmii_tx_ctl (rgmii_tx_ctl),
		.rgmii_tx_clk (rgmii_tx_clk),
		.phy_rstn     (phy_rstn),
		.led          (led)
	);

	initial begin
		tx_clk = 1'b0;
		forever #4 tx_clk = ~tx_clk;
	end

	// TX nibbles sampled mid-phase, RX nibbles driven 1 ns after each edge
	initial begin
		forever begin
			@(posedge tx_clk);
			#1;
			dec_lo = rgmii_txd;
			dec_ctl = rgmii_tx_ctl;
			rgmii_rxd = rx_byte.data[7:4];
			rgmii_rx_ctl = rx_byte.en ^ rx_byte.er;
			@(negedge tx_clk);
			#1;
			dec_byte.data = {rgmii_txd, dec_lo};
			dec_byte.en = dec_ctl;
			dec_byte.er = dec_ctl ^ rgmii_tx_ctl;
			if (dec_byte.en) begin
				if (!in_frame)
					cap_q.delete();
				in_frame = 1'b1;
				tx_er_seen = tx_er_seen | dec_byte.er;
				cap_q.push_back(dec_byte.data);
			end else if (in_frame) begin
				in_frame = 1'b0;
				last_frame = cap_q;
				frames_seen++;
			end
			// Loopback forwards the byte just decoded
			rx_byte = loopback ? dec_byte : inj_byte;
			rgmii_rxd = rx_byte.data[3:0];
			rgmii_rx_ctl = rx_byte.en;
		end
	end

	task automatic step(input int n);
		repeat (n) @(posedge tx_clk);
		#1;
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
		assert (got === want) else begin
			$display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, want);
			test_err++;
		end
	endtask

	// Mode 0, MSB first, 16 tx_clk periods per bit
	task automatic spi_write(input cfg_addr_e addr, input logic [LEN_W-1:0] data, input int nbits);
		logic [15:0] word;
		word = {addr, data};
		csb = 1'b0;
		step(8);
		for (int i = 0; i < nbits; i++) begin
			mosi = word[15 - i];
			step(8);
			sclk = 1'b1;
			step(8);
			sclk = 1'b0;
		end
		step(8);
		csb = 1'b1;
		step(8);
	endtask

	task automatic await_led(input logic [3:0] want, input int limit);
		int n;
		n = 0;
		while (led !== want && n < limit) begin
			step(1);
			n++;
		end
		check_val("led", led, want);
	endtask

	task automatic await_phy(input logic want, input int limit);
		int n;
		n = 0;
		while (phy_rstn !== want && n < limit) begin
			step(1);
			n++;
		end
		check_val("phy_rstn", phy_rstn, want);
	endtask

	task automatic await_frames(input int count, input int limit);
		int n;
		n = 0;
		while (frames_seen < count && n < limit) begin
			step(1);
			n++;
		end
		assert (frames_seen >= count) else begin
			$display("Timed out waiting for a frame on rgmii_tx_ctl");
			test_err++;
		end
	endtask

	task automatic inject_frame(input test_row_t row);
		gmii_t b;
		int    total;
		total = PREAMBLE_LEN + 1 + row.len;
		for (int i = 0; i < total; i++) begin
			b.en = 1'b1;
			b.er = 1'b0;
			if (i < PREAMBLE_LEN || row.kind == CORR_NO_SFD)
				b.data = PREAMBLE_BYTE;
			else if (i == PREAMBLE_LEN)
				b.data = SFD_BYTE;
			else
				b.data = row.seed + 8'(i - PREAMBLE_LEN - 1);
			// Damage the second payload byte
			if (i == PREAMBLE_LEN + 2 && row.kind == CORR_BYTE)
				b.data = b.data ^ 8'h80;
			if (i == PREAMBLE_LEN + 2 && row.kind == CORR_ER)
				b.er = 1'b1;
			inj_byte = b;
			step(1);
		end
		inj_byte = '0;
		step(1);
	endtask

	task automatic check_frame(input test_row_t row);
		logic [7:0] want;
		check_val("frame length", last_frame.size(), PREAMBLE_LEN + 1 + row.len);
		check_val("tx er", tx_er_seen, 0);
		for (int i = 0; i < last_frame.size(); i++) begin
			if (i < PREAMBLE_LEN)
				want = PREAMBLE_BYTE;
			else if (i == PREAMBLE_LEN)
				want = SFD_BYTE;
			else
				want = row.seed + 8'(i - PREAMBLE_LEN - 1);
			check_val($sformatf("rgmii_txd byte %0d", i), last_frame[i], want);
		end
	endtask

	task automatic end_test(input string name);
		if (test_err == 0) begin
			pass_cnt++;
			$display("PASS  %s", name);
		end else begin
			fail_cnt++;
			$display("FAIL  %s (%0d errors)", name, test_err);
		end
		test_err = 0;
	endtask

	task automatic build_table();
		int   good;
		logic bad;
		good = 0;
		bad = 1'b0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			rows[r].len = 12'(2 + $urandom % 39);
			rows[r].seed = 8'($urandom);
			rows[r].inject = (r >= 8 && r <= 11);
			rows[r].kind = CORR_NONE;
			rows[r].clear_first = 1'b0;
		end
		// One-byte frame, then a seed that wraps
		rows[0].len = 12'd1;
		rows[1].len = 12'd4;
		rows[1].seed = 8'hfd;
		rows[9].kind = CORR_BYTE;
		rows[10].kind = CORR_ER;
		rows[10].clear_first = 1'b1;
		rows[11].kind = CORR_NO_SFD;
		rows[11].clear_first = 1'b1;
		// Model of the checker's counters over the table
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (rows[r].clear_first) begin
				good = 0;
				bad = 1'b0;
			end
			if (!rows[r].inject || rows[r].kind == CORR_NONE)
				good++;
			else
				bad = 1'b1;
			rows[r].exp_led = {bad, good[2:0]};
		end
	endtask

	initial begin
		int          target;
		logic [3:0]  led_before;
		int          frames_before;
		test_row_t   busy_row;
		arst_n = 1'b0;
		sclk = 1'b0;
		csb = 1'b1;
		mosi = 1'b0;
		rgmii_rxd = '0;
		rgmii_rx_ctl = 1'b0;
		loopback = 1'b0;
		inj_byte = '0;
		rx_byte = '0;
		in_frame = 1'b0;
		tx_er_seen = 1'b0;
		frames_seen = 0;
		test_err = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		seed_val = 32'h58ff5aca;
		void'($urandom(seed_val));
		build_table();

		step(2);
		arst_n = 1'b1;
		check_val("led", led, 0);
		check_val("rgmii_tx_ctl", rgmii_tx_ctl, 0);
		check_val("phy_rstn", phy_rstn, 0);
		await_phy(1'b1, 40);
		// Forwarded clock follows tx_clk in both phases
		for (int i = 0; i < 30; i++) begin
			@(negedge tx_clk);
			#1;
			check_val("rgmii_tx_clk", rgmii_tx_clk, 0);
			step(1);
			check_val("phy_rstn", phy_rstn, 1);
			check_val("rgmii_tx_clk", rgmii_tx_clk, 1);
		end
		end_test("reset, PHY reset release and forwarded clock");

		spi_write(ADDR_CMD, 12'h004, 16);
		await_phy(1'b0, 20);
		spi_write(ADDR_CMD, 12'h000, 16);
		await_phy(1'b1, 20);
		end_test("PHY forced reset");

		for (int r = 0; r < NUM_ROWS; r++) begin
			if (rows[r].clear_first) begin
				spi_write(ADDR_CMD, 12'h002, 16);
				await_led(4'h0, 50);
			end
			if (rows[r].inject) begin
				loopback = 1'b0;
				inject_frame(rows[r]);
			end else begin
				loopback = 1'b1;
				tx_er_seen = 1'b0;
				spi_write(ADDR_LEN, rows[r].len, 16);
				spi_write(ADDR_SEED, 12'(rows[r].seed), 16);
				target = frames_seen + 1;
				spi_write(ADDR_CMD, 12'h001, 16);
				await_frames(target, rows[r].len + 100);
				check_frame(rows[r]);
			end
			await_led(rows[r].exp_led, 100);
			step(20);
			check_val("led", led, rows[r].exp_led);
			end_test($sformatf("row %0d len %0d seed 0x%h inject %0d kind %0d", r,
				rows[r].len, rows[r].seed, rows[r].inject, rows[r].kind));
		end

		// A 10-bit word must be dropped
		led_before = led;
		frames_before = frames_seen;
		spi_write(ADDR_CMD, 12'h001, 10);
		step(50);
		check_val("led", led, led_before);
		check_val("frame count", frames_seen, frames_before);
		check_val("phy_rstn", phy_rstn, 1);
		// Next frame still uses the last full LEN and SEED words
		loopback = 1'b1;
		tx_er_seen = 1'b0;
		target = frames_seen + 1;
		spi_write(ADDR_CMD, 12'h001, 16);
		await_frames(target, rows[NUM_ROWS-1].len + 100);
		check_frame(rows[NUM_ROWS-1]);
		spi_write(ADDR_CMD, 12'h002, 16);
		await_led(4'h0, 50);
		end_test("cut-off SPI word and clear");

		// Extra sends land while the long frame is still going out
		loopback = 1'b1;
		tx_er_seen = 1'b0;
		busy_row = '0;
		busy_row.len = 12'd1200;
		busy_row.seed = 8'h33;
		spi_write(ADDR_LEN, busy_row.len, 16);
		spi_write(ADDR_SEED, 12'(busy_row.seed), 16);
		target = frames_seen + 1;
		spi_write(ADDR_CMD, 12'h001, 16);
		spi_write(ADDR_CMD, 12'h001, 16);
		spi_write(ADDR_CMD, 12'h001, 16);
		await_frames(target, 2000);
		// Long enough for a queued second frame to go out completely
		step(1300);
		check_val("frame count", frames_seen, target);
		check_val("rgmii_tx_ctl", rgmii_tx_ctl, 0);
		check_frame(busy_row);
		end_test("busy guard");

		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
